/* source/axi_params.svh */
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// bus widths.
`define AXI_AW 32 // address bits.
`define AXI_DW 64 // data bits per beat.
`define AXI_SW 8  // one strobe per data byte.

// on-chip sram window, 64-bit words.
`define MEM_BASE  32'h8000_0000
`define MEM_WORDS 256

// a fetch line is two beats, 16 bytes.
`define FETCH_BEATS 2

`endif

/* source/axi_pkg.sv */
package axi_pkg;

   // read grant held by the arbiter.
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0, // no read in flight.
      ARB_IFU  = 2'd1, // fetch master owns AR and R.
      ARB_MEM  = 2'd2  // load/store master owns AR and R.
   } arb_state_e;

   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   // only the two responses the sram can give.
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } axi_resp_e;

   typedef enum logic [1:0] {
      BURST_INCR = 2'd1 // incrementing bursts only.
   } axi_burst_e;

endpackage

/* source/axi_arbiter.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module axi_arbiter (
   input  logic                clk,
   input  logic                rst,
   // fetch master read channels.
   input  logic [`AXI_AW-1:0]  araddr_ifu,
   input  logic [7:0]          arlen_ifu,
   input  logic [2:0]          arsize_ifu,
   input  axi_pkg::axi_burst_e arburst_ifu,
   input  logic                arvalid_ifu,
   output logic                arready_ifu,
   output logic [`AXI_DW-1:0]  rdata_ifu,
   output axi_pkg::axi_resp_e  rresp_ifu,
   output logic                rlast_ifu,
   output logic                rvalid_ifu,
   input  logic                rready_ifu,
   // load/store master read channels.
   input  logic [`AXI_AW-1:0]  araddr_mem,
   input  logic [7:0]          arlen_mem,
   input  logic [2:0]          arsize_mem,
   input  axi_pkg::axi_burst_e arburst_mem,
   input  logic                arvalid_mem,
   output logic                arready_mem,
   output logic [`AXI_DW-1:0]  rdata_mem,
   output axi_pkg::axi_resp_e  rresp_mem,
   output logic                rlast_mem,
   output logic                rvalid_mem,
   input  logic                rready_mem,
   // load/store master write channels.
   input  logic [`AXI_AW-1:0]  awaddr_mem,
   input  logic [7:0]          awlen_mem,
   input  logic [2:0]          awsize_mem,
   input  axi_pkg::axi_burst_e awburst_mem,
   input  logic                awvalid_mem,
   output logic                awready_mem,
   input  logic [`AXI_DW-1:0]  wdata_mem,
   input  logic [`AXI_SW-1:0]  wstrb_mem,
   input  logic                wlast_mem,
   input  logic                wvalid_mem,
   output logic                wready_mem,
   output axi_pkg::axi_resp_e  bresp_mem,
   output logic                bvalid_mem,
   input  logic                bready_mem,
   // slave side toward the sram.
   output logic [`AXI_AW-1:0]  araddr,
   output logic [7:0]          arlen,
   output logic [2:0]          arsize,
   output axi_pkg::axi_burst_e arburst,
   output logic                arvalid,
   input  logic                arready,
   input  logic [`AXI_DW-1:0]  rdata,
   input  axi_pkg::axi_resp_e  rresp,
   input  logic                rlast,
   input  logic                rvalid,
   output logic                rready,
   output logic [`AXI_AW-1:0]  awaddr,
   output logic [7:0]          awlen,
   output logic [2:0]          awsize,
   output axi_pkg::axi_burst_e awburst,
   output logic                awvalid,
   input  logic                awready,
   output logic [`AXI_DW-1:0]  wdata,
   output logic [`AXI_SW-1:0]  wstrb,
   output logic                wlast,
   output logic                wvalid,
   input  logic                wready,
   input  axi_pkg::axi_resp_e  bresp,
   input  logic                bvalid,
   output logic                bready
);
   import axi_pkg::*;

   arb_state_e state;
   logic       ifu_sel; // fetch master granted.
   logic       mem_sel; // load/store master granted.

   assign ifu_sel = (state == ARB_IFU);
   assign mem_sel = (state == ARB_MEM);

   // grant is taken in idle and held until the rlast beat is accepted.
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ARB_IDLE;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (arvalid_ifu) begin
                  state <= ARB_IFU; // fetch wins a tie.
               end else if (arvalid_mem) begin
                  state <= ARB_MEM;
               end
            end
            ARB_IFU, ARB_MEM: begin
               if (rvalid && rready && rlast) state <= ARB_IDLE;
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   // ar payload only matters while arvalid is forwarded.
   assign araddr  = mem_sel ? araddr_mem  : araddr_ifu;
   assign arlen   = mem_sel ? arlen_mem   : arlen_ifu;
   assign arsize  = mem_sel ? arsize_mem  : arsize_ifu;
   assign arburst = mem_sel ? arburst_mem : arburst_ifu;
   assign arvalid = (ifu_sel & arvalid_ifu) | (mem_sel & arvalid_mem); // never in idle.
   assign rready  = (ifu_sel & rready_ifu) | (mem_sel & rready_mem);

   // responses reach the winner only.
   assign arready_ifu = ifu_sel & arready;
   assign rdata_ifu   = ifu_sel ? rdata : '0;
   assign rresp_ifu   = ifu_sel ? rresp : RESP_OKAY;
   assign rlast_ifu   = ifu_sel & rlast;
   assign rvalid_ifu  = ifu_sel & rvalid;
   assign arready_mem = mem_sel & arready;
   assign rdata_mem   = mem_sel ? rdata : '0;
   assign rresp_mem   = mem_sel ? rresp : RESP_OKAY;
   assign rlast_mem   = mem_sel & rlast;
   assign rvalid_mem  = mem_sel & rvalid;

   // only the load/store master writes.
   assign awaddr      = awaddr_mem;
   assign awlen       = awlen_mem;
   assign awsize      = awsize_mem;
   assign awburst     = awburst_mem;
   assign awvalid     = awvalid_mem;
   assign awready_mem = awready;
   assign wdata       = wdata_mem;
   assign wstrb       = wstrb_mem;
   assign wlast       = wlast_mem;
   assign wvalid      = wvalid_mem;
   assign wready_mem  = wready;
   assign bresp_mem   = bresp;
   assign bvalid_mem  = bvalid;
   assign bready      = bready_mem;

endmodule

/* source/ifetch_master.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module ifetch_master (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            fetch_req,
   input  logic [`AXI_AW-1:0]              fetch_addr,
   output logic                            fetch_ack,
   output logic [`FETCH_BEATS*`AXI_DW-1:0] fetch_line,
   output logic                            fetch_err,
   output logic [`AXI_AW-1:0]              araddr,
   output logic [7:0]                      arlen,
   output logic [2:0]                      arsize,
   output axi_pkg::axi_burst_e             arburst,
   output logic                            arvalid,
   input  logic                            arready,
   input  logic [`AXI_DW-1:0]              rdata,
   input  axi_pkg::axi_resp_e              rresp,
   input  logic                            rlast,
   input  logic                            rvalid,
   output logic                            rready
);
   import axi_pkg::*;

   typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA, F_DONE} fetch_state_e;

   fetch_state_e                    state;
   logic [$clog2(`FETCH_BEATS)-1:0] beat; // next line slot to fill.

   assign arlen     = 8'(`FETCH_BEATS - 1);
   assign arsize    = 3'd3; // 8 bytes per beat.
   assign arburst   = BURST_INCR;
   assign rready    = 1'b1; // line is buffered here.
   assign fetch_ack = (state == F_DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= F_IDLE;
         arvalid <= 1'b0;
      end else begin
         case (state)
            F_IDLE: begin
               if (fetch_req) begin
                  arvalid <= 1'b1;
                  state   <= F_ADDR;
               end
            end
            F_ADDR: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  state   <= F_DATA;
               end
            end
            F_DATA:  if (rvalid && rlast) state <= F_DONE;
            F_DONE:  if (!fetch_req) state <= F_IDLE; // four-phase release.
            default: state <= F_IDLE;
         endcase
      end
   end

   // line assembly, low word first.
   always_ff @(posedge clk) begin
      if (state == F_IDLE && fetch_req) begin
         araddr    <= {fetch_addr[`AXI_AW-1:4], 4'h0}; // 16-byte aligned.
         beat      <= '0;
         fetch_err <= 1'b0;
      end else if (state == F_DATA && rvalid) begin
         fetch_line[beat*`AXI_DW +: `AXI_DW] <= rdata;
         beat <= beat + 1'b1;
         if (rresp == RESP_SLVERR) fetch_err <= 1'b1; // sticky over the burst.
      end
   end

endmodule

/* source/lsu_master.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module lsu_master (
   input  logic                clk,
   input  logic                rst,
   input  logic                lsu_req,
   input  axi_pkg::lsu_op_e    lsu_op,
   input  logic [`AXI_AW-1:0]  lsu_addr,
   input  logic [`AXI_DW-1:0]  lsu_wdata,
   input  logic [`AXI_SW-1:0]  lsu_wstrb,
   output logic                lsu_ack,
   output logic [`AXI_DW-1:0]  lsu_rdata,
   output logic                lsu_err,
   output logic [`AXI_AW-1:0]  araddr,
   output logic [7:0]          arlen,
   output logic [2:0]          arsize,
   output axi_pkg::axi_burst_e arburst,
   output logic                arvalid,
   input  logic                arready,
   input  logic [`AXI_DW-1:0]  rdata,
   input  axi_pkg::axi_resp_e  rresp,
   input  logic                rlast,
   input  logic                rvalid,
   output logic                rready,
   output logic [`AXI_AW-1:0]  awaddr,
   output logic [7:0]          awlen,
   output logic [2:0]          awsize,
   output axi_pkg::axi_burst_e awburst,
   output logic                awvalid,
   input  logic                awready,
   output logic [`AXI_DW-1:0]  wdata,
   output logic [`AXI_SW-1:0]  wstrb,
   output logic                wlast,
   output logic                wvalid,
   input  logic                wready,
   input  axi_pkg::axi_resp_e  bresp,
   input  logic                bvalid,
   output logic                bready
);
   import axi_pkg::*;

   typedef enum logic [2:0] {L_IDLE, L_RADDR, L_RDATA, L_WRITE, L_DONE} lsu_state_e;

   lsu_state_e         state;
   logic [`AXI_AW-1:0] addr_q; // shared by ar and aw.

   // single-beat, 8-byte transfers.
   assign araddr  = addr_q;
   assign arlen   = 8'd0;
   assign arsize  = 3'd3;
   assign arburst = BURST_INCR;
   assign awaddr  = addr_q;
   assign awlen   = 8'd0;
   assign awsize  = 3'd3;
   assign awburst = BURST_INCR;
   assign wlast   = 1'b1;
   assign rready  = 1'b1;
   assign bready  = 1'b1;
   assign lsu_ack = (state == L_DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= L_IDLE;
         arvalid <= 1'b0;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
      end else begin
         case (state)
            L_IDLE: begin
               if (lsu_req && lsu_op == LSU_STORE) begin
                  awvalid <= 1'b1; // aw and w go out together.
                  wvalid  <= 1'b1;
                  state   <= L_WRITE;
               end else if (lsu_req) begin
                  arvalid <= 1'b1;
                  state   <= L_RADDR;
               end
            end
            L_RADDR: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  state   <= L_RDATA;
               end
            end
            L_RDATA: if (rvalid && rlast) state <= L_DONE;
            L_WRITE: begin
               if (awready) awvalid <= 1'b0; // each channel drops on its own handshake.
               if (wready) wvalid <= 1'b0;
               if (bvalid) state <= L_DONE;
            end
            L_DONE:  if (!lsu_req) state <= L_IDLE;
            default: state <= L_IDLE;
         endcase
      end
   end

   // request payload and held result.
   always_ff @(posedge clk) begin
      if (state == L_IDLE && lsu_req) begin
         addr_q  <= lsu_addr;
         wdata   <= lsu_wdata;
         wstrb   <= lsu_wstrb;
         lsu_err <= 1'b0;
      end else if (state == L_RDATA && rvalid) begin
         lsu_rdata <= rdata;
         lsu_err   <= (rresp == RESP_SLVERR);
      end else if (state == L_WRITE && bvalid) begin
         lsu_err <= (bresp == RESP_SLVERR);
      end
   end

endmodule

/* source/axi_sram.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module axi_sram (
   input  logic                clk,
   input  logic                rst,
   input  logic [`AXI_AW-1:0]  araddr,
   input  logic [7:0]          arlen,
   input  logic [2:0]          arsize,
   input  axi_pkg::axi_burst_e arburst,
   input  logic                arvalid,
   output logic                arready,
   output logic [`AXI_DW-1:0]  rdata,
   output axi_pkg::axi_resp_e  rresp,
   output logic                rlast,
   output logic                rvalid,
   input  logic                rready,
   input  logic [`AXI_AW-1:0]  awaddr,
   input  logic [7:0]          awlen,
   input  logic [2:0]          awsize,
   input  axi_pkg::axi_burst_e awburst,
   input  logic                awvalid,
   output logic                awready,
   input  logic [`AXI_DW-1:0]  wdata,
   input  logic [`AXI_SW-1:0]  wstrb,
   input  logic                wlast,
   input  logic                wvalid,
   output logic                wready,
   output axi_pkg::axi_resp_e  bresp,
   output logic                bvalid,
   input  logic                bready
);
   import axi_pkg::*;

   localparam int IW = $clog2(`MEM_WORDS); // word index bits.

   typedef enum logic [1:0] {R_IDLE, R_READ, R_DATA} rd_state_e;
   typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_e;

   rd_state_e          rd_st;
   wr_state_e          wr_st;
   logic [`AXI_DW-1:0] mem [`MEM_WORDS];
   logic [`AXI_AW-1:0] r_addr;  // address of the beat on the bus.
   logic [`AXI_AW-1:0] rd_addr; // address of the beat being loaded.
   logic [`AXI_AW-1:0] w_addr;
   logic [7:0]         r_left;  // beats after the current one.
   logic [7:0]         w_left;
   logic               r_bad;   // unsupported burst or size.
   logic               w_bad;
   logic               b_err;
   logic               rd_step; // load the next beat.
   logic               w_beat;
   logic               w_ok;

   function automatic logic in_window(input logic [`AXI_AW-1:0] a);
      return (a >= `MEM_BASE) && (a - `MEM_BASE < `MEM_WORDS * 8);
   endfunction

   function automatic logic [IW-1:0] word_of(input logic [`AXI_AW-1:0] a);
      logic [`AXI_AW-1:0] off;
      off = a - `MEM_BASE;
      return off[IW+2:3]; // byte offset over 8.
   endfunction

   assign arready = (rd_st == R_IDLE);
   assign rvalid  = (rd_st == R_DATA);
   assign rlast   = rvalid && (r_left == 8'd0);
   assign rd_step = (rd_st == R_READ) || (rvalid && rready && !rlast);
   assign rd_addr = (rd_st == R_READ) ? r_addr : r_addr + `AXI_AW'(8);

   // first beat 2 cycles after ar, then one per accepted beat.
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_st <= R_IDLE;
      end else begin
         case (rd_st)
            R_IDLE:  if (arvalid) rd_st <= R_READ;
            R_READ:  rd_st <= R_DATA;
            R_DATA:  if (rready && rlast) rd_st <= R_IDLE;
            default: rd_st <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         r_addr <= araddr;
         r_left <= arlen;
         r_bad  <= (arburst != BURST_INCR) || (arsize != 3'd3);
      end else if (rd_step) begin
         r_addr <= rd_addr;
         if (rd_st == R_DATA) r_left <= r_left - 1'b1;
         if (!r_bad && in_window(rd_addr)) begin
            rdata <= mem[word_of(rd_addr)];
            rresp <= RESP_OKAY;
         end else begin
            rdata <= '0; // error beats carry no data.
            rresp <= RESP_SLVERR;
         end
      end
   end

   assign awready = (wr_st == W_IDLE);
   assign wready  = (wr_st == W_DATA);
   assign bvalid  = (wr_st == W_RESP); // one cycle after the wlast beat.
   assign bresp   = b_err ? RESP_SLVERR : RESP_OKAY;
   assign w_beat  = wvalid && wready;
   assign w_ok    = !w_bad && in_window(w_addr);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_st <= W_IDLE;
      end else begin
         case (wr_st)
            W_IDLE:  if (awvalid) wr_st <= W_DATA;
            W_DATA:  if (w_beat && wlast) wr_st <= W_RESP;
            W_RESP:  if (bready) wr_st <= W_IDLE;
            default: wr_st <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         w_addr <= awaddr;
         w_left <= awlen;
         w_bad  <= (awburst != BURST_INCR) || (awsize != 3'd3);
         b_err  <= 1'b0;
      end else if (w_beat) begin
         w_addr <= w_addr + `AXI_AW'(8);
         w_left <= w_left - 1'b1;
         // bad address, or wlast not matching awlen.
         if (!w_ok || (wlast != (w_left == 8'd0))) b_err <= 1'b1;
      end
   end

   // byte lanes without strobe keep their old value.
   always_ff @(posedge clk) begin
      for (int i = 0; i < `AXI_SW; i++) begin
         if (w_beat && w_ok && wstrb[i]) mem[word_of(w_addr)][i*8 +: 8] <= wdata[i*8 +: 8];
      end
   end

endmodule

/* source/mem_subsys_top.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module mem_subsys_top (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            fetch_req,
   input  logic [`AXI_AW-1:0]              fetch_addr,
   output logic                            fetch_ack,
   output logic [`FETCH_BEATS*`AXI_DW-1:0] fetch_line,
   output logic                            fetch_err,
   input  logic                            lsu_req,
   input  axi_pkg::lsu_op_e                lsu_op,
   input  logic [`AXI_AW-1:0]              lsu_addr,
   input  logic [`AXI_DW-1:0]              lsu_wdata,
   input  logic [`AXI_SW-1:0]              lsu_wstrb,
   output logic                            lsu_ack,
   output logic [`AXI_DW-1:0]              lsu_rdata,
   output logic                            lsu_err
);
   import axi_pkg::*;

   // _ifu and _mem wires are master side, bare names are the sram port.
   logic [`AXI_AW-1:0] araddr_ifu, araddr_mem, araddr, awaddr_mem, awaddr;
   logic [7:0]         arlen_ifu, arlen_mem, arlen, awlen_mem, awlen;
   logic [2:0]         arsize_ifu, arsize_mem, arsize, awsize_mem, awsize;
   axi_burst_e         arburst_ifu, arburst_mem, arburst, awburst_mem, awburst;
   axi_resp_e          rresp_ifu, rresp_mem, rresp, bresp_mem, bresp;
   logic [`AXI_DW-1:0] rdata_ifu, rdata_mem, rdata, wdata_mem, wdata;
   logic [`AXI_SW-1:0] wstrb_mem, wstrb;
   logic               arvalid_ifu, arready_ifu, rlast_ifu, rvalid_ifu, rready_ifu;
   logic               arvalid_mem, arready_mem, rlast_mem, rvalid_mem, rready_mem;
   logic               awvalid_mem, awready_mem, wlast_mem, wvalid_mem, wready_mem;
   logic               bvalid_mem, bready_mem;
   logic               arvalid, arready, rlast, rvalid, rready;
   logic               awvalid, awready, wlast, wvalid, wready, bvalid, bready;

   ifetch_master u_ifu (
      .clk, .rst, .fetch_req, .fetch_addr, .fetch_ack, .fetch_line, .fetch_err,
      .araddr(araddr_ifu), .arlen(arlen_ifu), .arsize(arsize_ifu), .arburst(arburst_ifu),
      .arvalid(arvalid_ifu), .arready(arready_ifu), .rdata(rdata_ifu), .rresp(rresp_ifu),
      .rlast(rlast_ifu), .rvalid(rvalid_ifu), .rready(rready_ifu)
   );

   lsu_master u_lsu (
      .clk, .rst, .lsu_req, .lsu_op, .lsu_addr, .lsu_wdata, .lsu_wstrb,
      .lsu_ack, .lsu_rdata, .lsu_err,
      .araddr(araddr_mem), .arlen(arlen_mem), .arsize(arsize_mem), .arburst(arburst_mem),
      .arvalid(arvalid_mem), .arready(arready_mem), .rdata(rdata_mem), .rresp(rresp_mem),
      .rlast(rlast_mem), .rvalid(rvalid_mem), .rready(rready_mem),
      .awaddr(awaddr_mem), .awlen(awlen_mem), .awsize(awsize_mem), .awburst(awburst_mem),
      .awvalid(awvalid_mem), .awready(awready_mem), .wdata(wdata_mem), .wstrb(wstrb_mem),
      .wlast(wlast_mem), .wvalid(wvalid_mem), .wready(wready_mem),
      .bresp(bresp_mem), .bvalid(bvalid_mem), .bready(bready_mem)
   );

   // wire names match the arbiter and sram ports.
   axi_arbiter u_arb (.*);

   axi_sram u_sram (.*);

endmodule

/* sim/mem_subsys_chk.sv */
`timescale 1ns/10ps

module mem_subsys_chk (
   input logic                clk,
   input logic                rst,
   input logic                fetch_req,
   input logic                fetch_ack,
   input logic                lsu_req,
   input logic                lsu_ack,
   input axi_pkg::arb_state_e arb_state, // registered read grant.
   input logic                arvalid,   // forwarded to the sram.
   input logic                rvalid,
   input logic                rready,
   input logic                rlast
);
   import axi_pkg::*;

   logic r_done; // last read beat accepted.

   assign r_done = rvalid && rready && rlast;

   // four-phase rules on both client ports.
   fetch_ack_rise: assert property (@(posedge clk) disable iff (rst)
      $rose(fetch_ack) |-> fetch_req) else $error("fetch_ack rose without fetch_req");
   lsu_ack_rise: assert property (@(posedge clk) disable iff (rst)
      $rose(lsu_ack) |-> lsu_req) else $error("lsu_ack rose without lsu_req");
   fetch_ack_hold: assert property (@(posedge clk) disable iff (rst)
      fetch_ack && fetch_req |=> fetch_ack) else $error("fetch_ack dropped while req high");
   lsu_ack_hold: assert property (@(posedge clk) disable iff (rst)
      lsu_ack && lsu_req |=> lsu_ack) else $error("lsu_ack dropped while req high");

   // both acks come out of reset low.
   ack_reset: assert property (@(posedge clk)
      rst |=> !fetch_ack && !lsu_ack) else $error("ack high after reset");

   // nothing reaches the sram without a grant.
   idle_no_ar: assert property (@(posedge clk) disable iff (rst)
      arb_state == ARB_IDLE |-> !arvalid) else $error("arvalid forwarded in idle");

   grant_hold: assert property (@(posedge clk) disable iff (rst)
      arb_state != ARB_IDLE && !r_done |=> arb_state == $past(arb_state))
      else $error("read grant changed before the rlast handshake");

endmodule

// the grant state lives inside the arbiter instance.
bind mem_subsys_top mem_subsys_chk chk (
   .clk, .rst, .fetch_req, .fetch_ack, .lsu_req, .lsu_ack,
   .arb_state(u_arb.state), .arvalid, .rvalid, .rready, .rlast
);

/* sim/mem_subsys_tb.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module mem_subsys_tb;
   import axi_pkg::*;

   logic                            clk;
   logic                            rst;
   logic                            fetch_req;
   logic [`AXI_AW-1:0]              fetch_addr;
   logic                            fetch_ack;
   logic [`FETCH_BEATS*`AXI_DW-1:0] fetch_line;
   logic                            fetch_err;
   logic                            lsu_req;
   lsu_op_e                         lsu_op;
   logic [`AXI_AW-1:0]              lsu_addr;
   logic [`AXI_DW-1:0]              lsu_wdata;
   logic [`AXI_SW-1:0]              lsu_wstrb;
   logic                            lsu_ack;
   logic [`AXI_DW-1:0]              lsu_rdata;
   logic                            lsu_err;
   logic [`AXI_DW-1:0]              model_mem [`MEM_WORDS]; // expected sram contents.
   int                              seed;

   mem_subsys_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period.
   end

   function automatic logic in_window(input logic [31:0] a);
      return (a >= `MEM_BASE) && (a < `MEM_BASE + `MEM_WORDS * 8);
   endfunction

   function automatic logic [7:0] word_index(input logic [31:0] a);
      logic [31:0] off;
      off = (a - `MEM_BASE) >> 3; // 8 bytes per word.
      return off[7:0];
   endfunction

   function automatic logic [31:0] word_addr(input logic [7:0] w);
      return `MEM_BASE + {21'd0, w, 3'd0};
   endfunction

   // enabled lanes take new data, the rest keep the old word.
   function automatic logic [63:0] apply_strobe(input logic [63:0] old, input logic [63:0] data,
                                                input logic [7:0] strb);
      logic [63:0] res;
      res = old;
      for (int i = 0; i < 8; i++) begin
         if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
      end
      return res;
   endfunction

   task automatic end_in_failure(input string why);
      $display("Some tests failed");
      $fatal(1, "%s", why);
   endtask

   task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
      assert (act === exp) else begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         end_in_failure("value mismatch");
      end
   endtask

   // outputs are sampled on the falling edge, away from the drive edge.
   task automatic wait_lsu_ack(input logic level);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (lsu_ack !== level && cycles < 200) begin
         @(negedge clk);
         cycles++;
      end
      if (lsu_ack !== level) end_in_failure("timed out waiting for lsu_ack");
   endtask

   task automatic wait_fetch_ack(input logic level);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (fetch_ack !== level && cycles < 200) begin
         @(negedge clk);
         cycles++;
      end
      if (fetch_ack !== level) end_in_failure("timed out waiting for fetch_ack");
   endtask

   // one full four-phase load or store, checked against the model.
   task automatic lsu_access(input string name, input lsu_op_e op, input logic [31:0] addr,
                             input logic [63:0] data, input logic [7:0] strb);
      logic [63:0] exp_rdata;
      logic        exp_err;
      exp_err   = !in_window(addr);
      exp_rdata = exp_err ? 64'd0 : model_mem[word_index(addr)]; // error reads give zero.
      @(posedge clk);
      lsu_req   <= 1'b1;
      lsu_op    <= op;
      lsu_addr  <= addr;
      lsu_wdata <= data;
      lsu_wstrb <= strb;
      wait_lsu_ack(1'b1);
      if (op == LSU_LOAD) check_value({name, " rdata"}, 128'(exp_rdata), 128'(lsu_rdata));
      check_value({name, " lsu_err"}, 128'(exp_err), 128'(lsu_err));
      if (op == LSU_STORE && !exp_err) begin
         model_mem[word_index(addr)] = apply_strobe(model_mem[word_index(addr)], data, strb);
      end
      @(posedge clk);
      lsu_req <= 1'b0;
      wait_lsu_ack(1'b0);
   endtask

   task automatic fetch_and_compare(input string name, input logic [31:0] addr);
      logic [31:0]  line_addr;
      logic [7:0]   w;
      logic [127:0] exp_line;
      logic         exp_err;
      line_addr = {addr[31:4], 4'h0};
      exp_err   = !in_window(line_addr);
      w         = word_index(line_addr);
      exp_line  = exp_err ? 128'd0 : {model_mem[w + 8'd1], model_mem[w]}; // low word first.
      @(posedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      wait_fetch_ack(1'b1);
      check_value({name, " line"}, exp_line, fetch_line);
      check_value({name, " fetch_err"}, 128'(exp_err), 128'(fetch_err));
      @(posedge clk);
      fetch_req <= 1'b0;
      wait_fetch_ack(1'b0);
   endtask

   // both requests stay high through the reset, so only the reset can clear the acks.
   task automatic reset_with_acks_high();
      fork
         begin
            @(posedge clk);
            fetch_req  <= 1'b1;
            fetch_addr <= word_addr(8'd12);
            wait_fetch_ack(1'b1);
         end
         begin
            @(posedge clk);
            lsu_req  <= 1'b1;
            lsu_op   <= LSU_LOAD;
            lsu_addr <= word_addr(8'd3);
            wait_lsu_ack(1'b1);
         end
      join
      @(posedge clk);
      rst <= 1'b1;
      @(posedge clk);
      rst       <= 1'b0;
      fetch_req <= 1'b0;
      lsu_req   <= 1'b0;
      wait_fetch_ack(1'b0);
      wait_lsu_ack(1'b0);
   endtask

   task automatic verify_all_words(input string name);
      for (int i = 0; i < `MEM_WORDS; i++) lsu_access(name, LSU_LOAD, word_addr(8'(i)), 0, 0);
   endtask

   initial begin
      logic [31:0] rnd;
      logic [31:0] a;
      logic [7:0]  w;
      logic [63:0] data;
      lsu_op_e     op;
      seed       = 58;
      rst        = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      lsu_req    = 1'b0;
      lsu_op     = LSU_LOAD;
      lsu_addr   = '0;
      lsu_wdata  = '0;
      lsu_wstrb  = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // fill pattern follows the whole address, then read it all back.
      for (int i = 0; i < `MEM_WORDS; i++) begin
         a = word_addr(8'(i));
         lsu_access("fill", LSU_STORE, a, {~a, a}, 8'hff);
      end
      verify_all_words("store then load");

      // partial strobes.
      lsu_access("partial", LSU_STORE, word_addr(8'd5), 64'h1111_2222_3333_4444, 8'h0f);
      lsu_access("partial", LSU_STORE, word_addr(8'd6), 64'h5555_6666_7777_8888, 8'ha5);
      lsu_access("partial", LSU_STORE, word_addr(8'd7), 64'h9999_aaaa_bbbb_cccc, 8'h80);
      for (int i = 5; i < 8; i++) lsu_access("partial", LSU_LOAD, word_addr(8'(i)), 0, 0);

      // any offset inside a line gives the same line.
      for (int i = 0; i < 16; i += 5) begin
         fetch_and_compare("fetch", word_addr(8'd0) + 32'(i));
         fetch_and_compare("fetch", word_addr(8'd20) + 32'(i));
         fetch_and_compare("fetch", word_addr(8'd254) + 32'(i));
      end

      // same-edge contention, load then store against another line.
      fork
         lsu_access("contention", LSU_LOAD, word_addr(8'd9), 0, 0);
         fetch_and_compare("contention", word_addr(8'd9));
      join
      fork
         lsu_access("contention", LSU_STORE, word_addr(8'd40), 64'hdead_beef_0bad_f00d, 8'hff);
         fetch_and_compare("contention", word_addr(8'd42));
      join

      reset_with_acks_high(); // sram contents survive the reset.

      // outside the window.
      fetch_and_compare("oow fetch", 32'h7fff_fff0);
      fetch_and_compare("oow fetch", `MEM_BASE + 32'h800);
      lsu_access("oow load", LSU_LOAD, 32'h7fff_fff8, 0, 0);
      lsu_access("oow load", LSU_LOAD, `MEM_BASE + 32'h800, 0, 0);
      lsu_access("oow store", LSU_STORE, 32'h7fff_fff8, 64'hffff_ffff_ffff_ffff, 8'hff);
      lsu_access("oow store", LSU_STORE, `MEM_BASE + 32'h800, 64'h0123_4567_89ab_cdef, 8'hff);
      lsu_access("oow store", LSU_STORE, 32'h0000_0100, 64'h0f0f_0f0f_0f0f_0f0f, 8'hff);
      verify_all_words("oow sweep");

      for (int n = 0; n < 200; n++) begin
         rnd  = $random(seed);
         data = {$random(seed), $random(seed)};
         w    = rnd[7:0];
         a    = word_addr(w);
         op   = rnd[24] ? LSU_STORE : LSU_LOAD;
         case (rnd[17:16])
            2'd0: lsu_access("random load", LSU_LOAD, a, 0, 0);
            2'd1: lsu_access("random store", LSU_STORE, a, data, rnd[15:8]);
            2'd2: fetch_and_compare("random fetch", {a[31:4], rnd[23:20]});
            default: begin
               fork // w ^ 2 lands in the neighbouring line.
                  lsu_access("random overlap", op, a, data, rnd[15:8]);
                  fetch_and_compare("random overlap", word_addr(w ^ 8'd2));
               join
            end
         endcase
      end
      verify_all_words("final sweep");

      $display("All tests passed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+source
source/axi_pkg.sv
source/axi_arbiter.sv
source/ifetch_master.sv
source/lsu_master.sv
source/axi_sram.sv
source/mem_subsys_top.sv
sim/mem_subsys_chk.sv
sim/mem_subsys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module mem_subsys_tb -f verilog.f -o mem_subsys_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/mem_subsys_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation ended with status $status"
   exit "$status"
fi

exit 0
